/* lc3b_btb.f */
+incdir+test
source/lc3b_btb_pkg.sv
source/tag_match.sv
source/plru_tree.sv
source/btb.sv
test/btb_properties.sv
test/btb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the btb testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module btb_tb \
	-f lc3b_btb.f \
	-o btb_sim

# a fatal error exits nonzero, so keep the output and decide on its contents
output="$(./obj_dir/btb_sim 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qF "=== PASS ==="; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* source/btb.sv */
`timescale 1ns/1ps

module btb (
	input  logic                     clk,
	input  logic                     reset,
	// fetch side lookup
	input  lc3b_btb_pkg::lc3b_word   pc_if,
	// writeback side update
	input  lc3b_btb_pkg::lc3b_word   pc_wb,
	input  lc3b_btb_pkg::lc3b_word   target_wb,
	input  lc3b_btb_pkg::lc3b_opcode opcode_wb,
	input  logic                     valid_wb,
	// prediction back to fetch
	output lc3b_btb_pkg::lc3b_word   predict_target,
	output logic                     predict_hit
);

	// index and tag of both pcs
	lc3b_btb_pkg::btb_index index_if;
	lc3b_btb_pkg::btb_tag   tag_if;
	lc3b_btb_pkg::btb_index index_wb;
	lc3b_btb_pkg::btb_tag   tag_wb;

	// storage arrays, all flops
	lc3b_btb_pkg::btb_tag   tag_array    [lc3b_btb_pkg::BTB_SETS][lc3b_btb_pkg::BTB_WAYS];
	lc3b_btb_pkg::lc3b_word target_array [lc3b_btb_pkg::BTB_SETS][lc3b_btb_pkg::BTB_WAYS];
	logic [lc3b_btb_pkg::BTB_WAYS-1:0] valid_array [lc3b_btb_pkg::BTB_SETS];
	lc3b_btb_pkg::plru_bits plru_array   [lc3b_btb_pkg::BTB_SETS];

	// selected set contents for each compare
	lc3b_btb_pkg::btb_tag   lookup_tags [lc3b_btb_pkg::BTB_WAYS];
	lc3b_btb_pkg::btb_tag   wb_tags     [lc3b_btb_pkg::BTB_WAYS];
	logic [lc3b_btb_pkg::BTB_WAYS-1:0] lookup_valids;
	logic [lc3b_btb_pkg::BTB_WAYS-1:0] wb_valids;

	// compare results
	logic                   lookup_hit;
	lc3b_btb_pkg::btb_way   lookup_way;
	logic                   wb_hit;
	lc3b_btb_pkg::btb_way   wb_way;

	// tree outputs for the writeback set
	lc3b_btb_pkg::btb_way   wb_victim;
	lc3b_btb_pkg::plru_bits wb_plru_next;

	// qualifying writeback
	logic                   wb_update;

	// pc fields
	assign index_if = pc_if[lc3b_btb_pkg::BTB_INDEX_LSB +: lc3b_btb_pkg::BTB_INDEX_BITS];
	assign tag_if   = pc_if[lc3b_btb_pkg::BTB_TAG_LSB +: lc3b_btb_pkg::BTB_TAG_BITS];
	assign index_wb = pc_wb[lc3b_btb_pkg::BTB_INDEX_LSB +: lc3b_btb_pkg::BTB_INDEX_BITS];
	assign tag_wb   = pc_wb[lc3b_btb_pkg::BTB_TAG_LSB +: lc3b_btb_pkg::BTB_TAG_BITS];

	// read out the fetch set
	always_comb begin
		for (int w = 0; w < lc3b_btb_pkg::BTB_WAYS; w++) begin
			lookup_tags[w] = tag_array[index_if][w];
		end
		lookup_valids = valid_array[index_if];
	end

	// read out the writeback set
	always_comb begin
		for (int w = 0; w < lc3b_btb_pkg::BTB_WAYS; w++) begin
			wb_tags[w] = tag_array[index_wb][w];
		end
		wb_valids = valid_array[index_wb];
	end

	// fetch side compare
	tag_match lookup_match (
		.tags   (lookup_tags),
		.valids (lookup_valids),
		.tag    (tag_if),
		.hit    (lookup_hit),
		.way    (lookup_way)
	);

	// writeback side compare
	// decides between a refresh and an install
	tag_match wb_match (
		.tags   (wb_tags),
		.valids (wb_valids),
		.tag    (tag_wb),
		.hit    (wb_hit),
		.way    (wb_way)
	);

	// replacement for the writeback set
	plru_tree wb_plru (
		.state      (plru_array[index_wb]),
		.hit        (wb_hit),
		.hit_way    (wb_way),
		.victim     (wb_victim),
		.next_state (wb_plru_next)
	);

	// prediction
	// a miss falls through to pc_if so fetch keeps going sequentially
	assign predict_hit    = lookup_hit;
	assign predict_target = lookup_hit ? target_array[index_if][lookup_way] : pc_if;

	// only retired branches train the buffer
	assign wb_update = valid_wb && (opcode_wb == lc3b_btb_pkg::op_br);

	// control state
	// tree bits move on every qualifying writeback
	// valid is set only when a new entry goes in
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < lc3b_btb_pkg::BTB_SETS; s++) begin
				valid_array[s] <= '0;
				plru_array[s]  <= '0;
			end
		end else if (wb_update) begin
			plru_array[index_wb] <= wb_plru_next;
			if (!wb_hit) begin
				valid_array[index_wb][wb_victim] <= 1'b1;
			end
		end
	end

	// payload
	// install tag and target into the victim on a miss
	// a hit leaves the stored target as it is
	always_ff @(posedge clk) begin
		if (wb_update && !wb_hit) begin
			tag_array[index_wb][wb_victim]    <= tag_wb;
			target_array[index_wb][wb_victim] <= target_wb;
		end
	end

endmodule

/* source/lc3b_btb_pkg.sv */
package lc3b_btb_pkg;

	// machine word, used for both pcs and branch targets
	typedef logic [15:0] lc3b_word;

	// lc3b opcodes in the standard ir[15:12] encoding
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ld   = 4'b0010,
		op_st   = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// buffer geometry
	// four ways is fixed by the three-bit plru tree
	localparam int BTB_WAYS = 4;
	localparam int BTB_SETS = 32;

	// pc bit 0 is always zero for word aligned fetch
	// so the set index starts at bit 1
	localparam int BTB_INDEX_LSB = 1;
	localparam int BTB_INDEX_BITS = 5;

	// everything above the index is tag
	localparam int BTB_TAG_LSB = 6;
	localparam int BTB_TAG_BITS = 10;

	// set number
	typedef logic [BTB_INDEX_BITS-1:0] btb_index;

	// stored tag per way
	typedef logic [BTB_TAG_BITS-1:0] btb_tag;

	// way number within a set
	typedef logic [1:0] btb_way;

	// per-set tree state
	// bit 2 is the root
	// bit 1 picks within ways 0 and 1
	// bit 0 picks within ways 2 and 3
	typedef logic [2:0] plru_bits;

endpackage

/* source/plru_tree.sv */
`timescale 1ns/1ps

module plru_tree (
	input  lc3b_btb_pkg::plru_bits state,
	input  logic                   hit,
	input  lc3b_btb_pkg::btb_way   hit_way,
	output lc3b_btb_pkg::btb_way   victim,
	output lc3b_btb_pkg::plru_bits next_state
);

	// way whose access is recorded into the tree
	lc3b_btb_pkg::btb_way touched;

	// victim walk
	// root low sends us to the pair of ways 0 and 1
	// root high sends us to the pair of ways 2 and 3
	always_comb begin
		if (!state[2]) begin
			// bit 1 picks inside the low pair
			if (!state[1]) begin
				victim = 2'd0;
			end else begin
				victim = 2'd1;
			end
		end else begin
			// bit 0 picks inside the high pair
			if (!state[0]) begin
				victim = 2'd2;
			end else begin
				victim = 2'd3;
			end
		end
	end

	// a hit refreshes the hit way
	// a miss fills the victim so the victim becomes most recent
	assign touched = hit ? hit_way : victim;

	// point the tree away from the touched way
	// the bit of the other pair is left alone
	always_comb begin
		next_state = state;
		case (touched)
			2'd0: begin
				// next victim lands in the high pair and way 1 in the low pair
				next_state[2] = 1'b1;
				next_state[1] = 1'b1;
			end
			2'd1: begin
				next_state[2] = 1'b1;
				next_state[1] = 1'b0;
			end
			2'd2: begin
				// next victim lands in the low pair and way 3 in the high pair
				next_state[2] = 1'b0;
				next_state[0] = 1'b1;
			end
			2'd3: begin
				next_state[2] = 1'b0;
				next_state[0] = 1'b0;
			end
		endcase
	end

endmodule

/* source/tag_match.sv */
`timescale 1ns/1ps

module tag_match (
	input  lc3b_btb_pkg::btb_tag                        tags [lc3b_btb_pkg::BTB_WAYS],
	input  logic [lc3b_btb_pkg::BTB_WAYS-1:0]           valids,
	input  lc3b_btb_pkg::btb_tag                        tag,
	output logic                                        hit,
	output lc3b_btb_pkg::btb_way                        way
);

	// one bit per way, set when that way holds the tag
	logic [lc3b_btb_pkg::BTB_WAYS-1:0] match;

	// per-way compare
	// a stale tag in an invalid way must never count
	always_comb begin
		for (int w = 0; w < lc3b_btb_pkg::BTB_WAYS; w++) begin
			match[w] = valids[w] && (tags[w] == tag);
		end
	end

	// any way matching is a hit
	assign hit = |match;

	// encode the matching way
	// walk downward so the lowest matching way is the last one written
	// only one way should ever match since tags are installed on a miss
	always_comb begin
		way = '0;
		for (int w = lc3b_btb_pkg::BTB_WAYS - 1; w >= 0; w--) begin
			if (match[w]) begin
				way = lc3b_btb_pkg::btb_way'(w);
			end
		end
	end

endmodule

/* test/btb_properties.sv */
`timescale 1ns/1ps

module btb_properties (
	input logic                   clk,
	input logic                   reset,
	input lc3b_btb_pkg::lc3b_word pc_if,
	input lc3b_btb_pkg::lc3b_word pc_wb,
	input lc3b_btb_pkg::lc3b_word predict_target,
	input logic                   predict_hit,
	input logic                   wb_update,
	input logic                   wb_hit
);

	// reset clears every valid bit, nothing hits right after it
	reset_clears_hits: assert property (@(posedge clk) reset |=> !predict_hit)
		else $error("predict_hit high in the cycle after reset");

	// a miss passes the fetch pc straight through
	miss_passes_pc: assert property (@(posedge clk) disable iff (reset)
		!predict_hit |-> (predict_target == pc_if))
		else $error("predict_target differs from pc_if on a miss");

	// an installed pc is found on the very next cycle
	install_then_hit: assert property (@(posedge clk) disable iff (reset)
		(wb_update && !wb_hit) |=> ((pc_if != $past(pc_wb)) || predict_hit))
		else $error("lookup missed a pc installed the cycle before");

endmodule

// attach to every btb instance
bind btb btb_properties props0 (
	.clk            (clk),
	.reset          (reset),
	.pc_if          (pc_if),
	.pc_wb          (pc_wb),
	.predict_target (predict_target),
	.predict_hit    (predict_hit),
	.wb_update      (wb_update),
	.wb_hit         (wb_hit)
);

/* test/btb_ref_model.svh */
`ifndef BTB_REF_MODEL_SVH
`define BTB_REF_MODEL_SVH

// shadow copy of the buffer contents
logic                   ref_valid  [lc3b_btb_pkg::BTB_SETS][lc3b_btb_pkg::BTB_WAYS];
lc3b_btb_pkg::btb_tag   ref_tag    [lc3b_btb_pkg::BTB_SETS][lc3b_btb_pkg::BTB_WAYS];
lc3b_btb_pkg::lc3b_word ref_target [lc3b_btb_pkg::BTB_SETS][lc3b_btb_pkg::BTB_WAYS];
lc3b_btb_pkg::plru_bits ref_plru   [lc3b_btb_pkg::BTB_SETS];

// search the set of pc, gives {hit, way}
// first valid match from way 0 upward
function automatic logic [2:0] ref_find(input lc3b_btb_pkg::lc3b_word pc);
	logic [2:0] found;
	found = 3'b000;
	for (int w = 0; w < lc3b_btb_pkg::BTB_WAYS; w++) begin
		if (!found[2] && ref_valid[pc[5:1]][w] && (ref_tag[pc[5:1]][w] == pc[15:6])) begin
			found = {1'b1, 2'(w)};
		end
	end
	return found;
endfunction

// expected {predict_hit, predict_target} for a fetch pc
function automatic logic [16:0] ref_lookup(input lc3b_btb_pkg::lc3b_word pc);
	logic [2:0] found;
	found = ref_find(pc);
	if (found[2]) begin
		return {1'b1, ref_target[pc[5:1]][found[1:0]]};
	end
	// miss falls through to the fetch pc
	return {1'b0, pc};
endfunction

// root 0 -> low pair, root 1 -> high pair, pair bit picks inside
function automatic lc3b_btb_pkg::btb_way ref_victim(input lc3b_btb_pkg::plru_bits state);
	if (state[2]) begin
		return state[0] ? 2'd3 : 2'd2;
	end
	return state[1] ? 2'd1 : 2'd0;
endfunction

// point the tree away from the touched way
function automatic lc3b_btb_pkg::plru_bits ref_touch(input lc3b_btb_pkg::plru_bits state,
		input lc3b_btb_pkg::btb_way way);
	lc3b_btb_pkg::plru_bits updated;
	case (way)
		2'd0: updated = {1'b1, 1'b1, state[0]};
		2'd1: updated = {1'b1, 1'b0, state[0]};
		2'd2: updated = {1'b0, state[1], 1'b1};
		default: updated = {1'b0, state[1], 1'b0};
	endcase
	return updated;
endfunction

// one rising edge of the buffer, reset first
function automatic void ref_update(input logic rst, input lc3b_btb_pkg::lc3b_word pc,
		input lc3b_btb_pkg::lc3b_word target, input lc3b_btb_pkg::lc3b_opcode op,
		input logic valid);
	logic [2:0]           found;
	lc3b_btb_pkg::btb_way way;
	logic [4:0]           set;
	if (rst) begin
		for (int s = 0; s < lc3b_btb_pkg::BTB_SETS; s++) begin
			for (int w = 0; w < lc3b_btb_pkg::BTB_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
			end
			ref_plru[s] = 3'b000;
		end
	end else if (valid && (op == lc3b_btb_pkg::op_br)) begin
		set = pc[5:1];
		found = ref_find(pc);
		if (found[2]) begin
			// hit only refreshes the tree
			way = found[1:0];
		end else begin
			way = ref_victim(ref_plru[set]);
			ref_valid[set][way] = 1'b1;
			ref_tag[set][way] = pc[15:6];
			ref_target[set][way] = target;
		end
		ref_plru[set] = ref_touch(ref_plru[set], way);
	end
endfunction

`endif

/* test/btb_tb.sv */
`timescale 1ns/1ps

module btb_tb;

	// run lengths in cycles
	// these size the timeout
	localparam int RESET_CYCLES = 8;
	localparam int SWEEP_LEN = 64;
	localparam int DIRECTED_LEN = 40;
	localparam int RANDOM_LEN = 400;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + SWEEP_LEN + DIRECTED_LEN + RANDOM_LEN);

	logic                     clk;
	logic                     reset;
	lc3b_btb_pkg::lc3b_word   pc_if;
	lc3b_btb_pkg::lc3b_word   pc_wb;
	lc3b_btb_pkg::lc3b_word   target_wb;
	lc3b_btb_pkg::lc3b_opcode opcode_wb;
	logic                     valid_wb;
	lc3b_btb_pkg::lc3b_word   predict_target;
	logic                     predict_hit;

	string       test_name;
	int          cycle_count = 0;
	logic [31:0] lfsr_state;

	`include "btb_ref_model.svh"

	btb dut0 (
		.clk            (clk),
		.reset          (reset),
		.pc_if          (pc_if),
		.pc_wb          (pc_wb),
		.target_wb      (target_wb),
		.opcode_wb      (opcode_wb),
		.valid_wb       (valid_wb),
		.predict_target (predict_target),
		.predict_hit    (predict_hit)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// 32-bit fibonacci lfsr with taps 32 22 2 1
	// one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// pc from a tag and a set number
	function automatic lc3b_btb_pkg::lc3b_word make_pc(input logic [9:0] tag,
			input logic [4:0] index);
		return {tag, index, 1'b0};
	endfunction

	// 16 pcs over sets 2 and 3
	// eight tags per set against four ways
	function automatic lc3b_btb_pkg::lc3b_word pool_pc(input logic [3:0] sel);
		return {7'd0, sel[3:1], 4'b0001, sel[0], 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h actual %h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	// all inputs change on the falling edge
	task automatic drive_cycle(input lc3b_btb_pkg::lc3b_word lookup,
			input lc3b_btb_pkg::lc3b_word wb_pc, input lc3b_btb_pkg::lc3b_word wb_target,
			input lc3b_btb_pkg::lc3b_opcode op, input logic wb_valid);
		@(negedge clk);
		pc_if = lookup;
		pc_wb = wb_pc;
		target_wb = wb_target;
		opcode_wb = op;
		valid_wb = wb_valid;
	endtask

	// retire a branch at pc and look it up in the same cycle
	task automatic writeback_branch(input lc3b_btb_pkg::lc3b_word pc,
			input lc3b_btb_pkg::lc3b_word target);
		drive_cycle(pc, pc, target, lc3b_btb_pkg::op_br, 1'b1);
	endtask

	// lookup with an idle writeback
	// prediction is checked at the next rising edge
	task automatic lookup_expect(input string name, input lc3b_btb_pkg::lc3b_word pc,
			input logic exp_hit, input lc3b_btb_pkg::lc3b_word exp_target);
		drive_cycle(pc, 16'h0000, 16'h0000, lc3b_btb_pkg::op_add, 1'b0);
		@(posedge clk);
		check_value({name, " hit"}, {15'd0, exp_hit}, {15'd0, predict_hit});
		check_value({name, " target"}, exp_target, predict_target);
	endtask

	// compare against the model and then advance the model by this edge
	always @(posedge clk) begin : compare
		logic [16:0] expected;
		if (!reset) begin
			expected = ref_lookup(pc_if);
			check_value({test_name, " model hit"}, {15'd0, expected[16]}, {15'd0, predict_hit});
			check_value({test_name, " model target"}, expected[15:0], predict_target);
		end
		ref_update(reset, pc_wb, target_wb, opcode_wb, valid_wb);
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [31:0]              bits;
		lc3b_btb_pkg::lc3b_word   rand_pc;
		lc3b_btb_pkg::lc3b_opcode rand_op;
		clk = 1'b0;
		reset = 1'b1;
		pc_if = 16'h0000;
		pc_wb = 16'h0000;
		target_wb = 16'h0000;
		opcode_wb = lc3b_btb_pkg::op_add;
		valid_wb = 1'b0;
		lfsr_state = 32'h14be;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// empty buffer across every set and several tags
		test_name = "sweep";
		for (int i = 0; i < SWEEP_LEN; i++) begin
			lookup_expect("sweep", 16'(i * 1026), 1'b0, 16'(i * 1026));
		end

		// single install
		// same index with another tag stays a miss
		test_name = "install";
		writeback_branch(16'h1234, 16'h4a60);
		lookup_expect("install hit", 16'h1234, 1'b1, 16'h4a60);
		lookup_expect("install alias", 16'h9234, 1'b0, 16'h9234);

		// not valid and then not a branch
		test_name = "ignored";
		drive_cycle(16'h0000, 16'h2468, 16'h1110, lc3b_btb_pkg::op_br, 1'b0);
		drive_cycle(16'h0000, 16'h2468, 16'h1110, lc3b_btb_pkg::op_add, 1'b1);
		lookup_expect("ignored", 16'h2468, 1'b0, 16'h2468);

		// fill order is 0 2 1 3 and leaves the tree at 000
		// so the fifth takes way 0
		test_name = "fill";
		for (int k = 1; k <= 4; k++) begin
			writeback_branch(make_pc(10'(k), 5'd7), 16'(16'h8000 + k));
		end
		for (int k = 1; k <= 4; k++) begin
			lookup_expect("fill", make_pc(10'(k), 5'd7), 1'b1, 16'(16'h8000 + k));
		end
		writeback_branch(make_pc(10'd5, 5'd7), 16'h8005);
		lookup_expect("fill evicted", make_pc(10'd1, 5'd7), 1'b0, make_pc(10'd1, 5'd7));
		for (int k = 2; k <= 5; k++) begin
			lookup_expect("fill kept", make_pc(10'(k), 5'd7), 1'b1, 16'(16'h8000 + k));
		end

		// tags 11..14 land in ways 0 2 1 3
		// touching way 0 gives 110 with victim way 2
		// touching way 2 then gives 011 with victim way 1
		test_name = "redirect";
		for (int k = 11; k <= 14; k++) begin
			writeback_branch(make_pc(10'(k), 5'd9), 16'(16'hc000 + k));
		end
		writeback_branch(make_pc(10'd11, 5'd9), 16'hc00b);
		writeback_branch(make_pc(10'd12, 5'd9), 16'hc00c);
		writeback_branch(make_pc(10'd15, 5'd9), 16'hc00f);
		lookup_expect("redirect evicted", make_pc(10'd13, 5'd9), 1'b0, make_pc(10'd13, 5'd9));
		lookup_expect("redirect kept", make_pc(10'd11, 5'd9), 1'b1, 16'hc00b);
		lookup_expect("redirect kept", make_pc(10'd12, 5'd9), 1'b1, 16'hc00c);
		lookup_expect("redirect kept", make_pc(10'd14, 5'd9), 1'b1, 16'hc00e);
		lookup_expect("redirect new", make_pc(10'd15, 5'd9), 1'b1, 16'hc00f);

		// random traffic on a small pool
		// checked by the compare process
		test_name = "random";
		for (int n = 0; n < RANDOM_LEN; n++) begin
			bits = random_bits(4);
			rand_pc = pool_pc(bits[3:0]);
			bits = random_bits(5);
			// half of the writebacks are branches
			rand_op = bits[4] ? lc3b_btb_pkg::op_br : lc3b_btb_pkg::lc3b_opcode'(bits[3:0]);
			bits = random_bits(4);
			drive_cycle(pool_pc(bits[3:0]), rand_pc, 16'h0000, rand_op, 1'b0);
			bits = random_bits(16);
			target_wb = bits[15:0];
			bits = random_bits(2);
			valid_wb = (bits[1:0] != 2'b00);
		end
		@(posedge clk);
		// the compare process finishes the last edge before the run ends
		@(negedge clk);

		$display("=== PASS ===");
		$finish;
	end

endmodule
